//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := icache_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
src/icache_cfg_pkg.sv
src/icache_bus_pkg.sv
src/icache_req_stage.sv
src/icache_way.sv
src/icache_hit_select.sv
src/icache_refill_ctrl.sv
src/icache_top.sv
tb/icache_props.sv
tb/icache_tb.sv

//--- src/icache_bus_pkg.sv
package icache_bus_pkg;

    import icache_cfg_pkg::*;

    // memory read types
    localparam logic [2:0] RD_TYPE_WORD = 3'b010;
    localparam logic [2:0] RD_TYPE_LINE = 3'b100;

    typedef struct packed {
        cache_addr_t addr;
        logic        uncached;
    } cpu_req_t;

    typedef struct packed {
        word_t data;
    } cpu_resp_t;

    typedef struct packed {
        logic [2:0]        rd_type;
        logic [ADDR_W-1:0] addr;
    } mem_rd_req_t;

    // one beat of returned read data
    typedef struct packed {
        word_t data;
        logic  last;
    } mem_rd_resp_t;

endpackage

//--- src/icache_cfg_pkg.sv
package icache_cfg_pkg;

    // address fields from the tag down to the byte offset
    localparam int ADDR_W         = 32;
    localparam int OFFSET_W       = 4;
    localparam int INDEX_W        = 8;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WORD_OFF_W     = 2;
    localparam int BYTE_OFF_W     = OFFSET_W - WORD_OFF_W;
    localparam int NUM_SETS       = 1 << INDEX_W;

    // line and way organisation
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS       = 2;
    localparam int WAY_ID_W       = 1;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits, as the memory returns it first
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_OFF_W-1:0] word_off;
        logic [BYTE_OFF_W-1:0] byte_off;
    } cache_addr_t;

    // what one way shows after a registered read
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        line_t            line;
    } way_out_t;

endpackage

//--- src/icache_hit_select.sv
`timescale 1ns/10ps

module icache_hit_select
    import icache_cfg_pkg::*, icache_bus_pkg::*;
(
    input  way_out_t  way_out [NUM_WAYS],

    input  logic      lookup_valid,
    input  cpu_req_t  lookup_req,

    // word from the refill controller
    input  logic      fill_valid,
    input  word_t     fill_word,

    // response channel
    output logic      resp_valid,
    input  logic      resp_ready,
    output cpu_resp_t resp,

    output logic      lookup_miss,
    output logic      lookup_done
);

    logic [NUM_WAYS-1:0] hit_vec;
    logic                hit_cached;
    word_t               hit_word;

    // tag compare per way and word pick from the matching line
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = way_out[w].valid && (way_out[w].tag == lookup_req.addr.tag);
            if (hit_vec[w]) begin
                hit_word = way_out[w].line[lookup_req.addr.word_off];
            end
        end
    end

    // uncached requests never hit
    assign hit_cached = (|hit_vec) && !lookup_req.uncached;

    assign lookup_miss = lookup_valid && !hit_cached;
    assign resp_valid  = lookup_valid && (hit_cached || fill_valid);
    assign lookup_done = resp_valid && resp_ready;

    assign resp.data = hit_cached ? hit_word : fill_word;

endmodule

//--- src/icache_refill_ctrl.sv
`timescale 1ns/10ps

module icache_refill_ctrl
    import icache_cfg_pkg::*, icache_bus_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,

    // lookup status
    input  cpu_req_t            lookup_req,
    input  logic                lookup_miss,
    input  logic                lookup_done,

    // memory read channel
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output mem_rd_req_t         mem_req,
    input  logic                mem_resp_valid,
    input  mem_rd_resp_t        mem_resp,

    // word back to hit-select
    output logic                fill_valid,
    output word_t               fill_word,

    // way write port
    output logic [NUM_WAYS-1:0] wr_en,
    output logic [INDEX_W-1:0]  wr_index,
    output logic [TAG_W-1:0]    wr_tag,
    output line_t               wr_line
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_COLLECT,
        ST_RESPOND
    } state_t;

    state_t                state;
    logic [WORD_OFF_W-1:0] beat_cnt;
    logic [WAY_ID_W-1:0]   rr_ptr;
    line_t                 line_buf;
    line_t                 line_next;
    logic                  beat_take;
    logic                  last_take;
    logic                  line_write;

    // memory request built straight from the held lookup
    assign mem_req_valid   = (state == ST_REQUEST);
    assign mem_req.rd_type = lookup_req.uncached ? RD_TYPE_WORD : RD_TYPE_LINE;
    assign mem_req.addr    = lookup_req.uncached ? ADDR_W'(lookup_req.addr) :
                             {lookup_req.addr.tag, lookup_req.addr.index, {OFFSET_W{1'b0}}};

    assign beat_take  = (state == ST_COLLECT) && mem_resp_valid;
    assign last_take  = beat_take && mem_resp.last;
    assign line_write = last_take && !lookup_req.uncached;

    // buffered beats plus the one arriving now
    always_comb begin
        line_next           = line_buf;
        line_next[beat_cnt] = mem_resp.data;
    end

    // ways take the full line on the edge of the last beat
    assign wr_index = lookup_req.addr.index;
    assign wr_tag   = lookup_req.addr.tag;
    assign wr_line  = line_next;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            wr_en[w] = line_write && (rr_ptr == WAY_ID_W'(w));
        end
    end

    assign fill_valid = (state == ST_RESPOND);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
            rr_ptr   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (lookup_miss) begin
                        state <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (mem_req_ready) begin
                        beat_cnt <= '0;
                        state    <= ST_COLLECT;
                    end
                end
                ST_COLLECT: begin
                    if (beat_take) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_take) begin
                        state <= ST_RESPOND;
                    end
                    // round robin moves on every cached fill
                    if (line_write) begin
                        rr_ptr <= rr_ptr + 1'b1;
                    end
                end
                ST_RESPOND: begin
                    if (lookup_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // line buffer and returned word
    always_ff @(posedge clk) begin
        if (beat_take) begin
            line_buf <= line_next;
        end
        if (last_take) begin
            fill_word <= lookup_req.uncached ? mem_resp.data :
                         line_next[lookup_req.addr.word_off];
        end
    end

endmodule

//--- src/icache_req_stage.sv
`timescale 1ns/10ps

module icache_req_stage
    import icache_cfg_pkg::*, icache_bus_pkg::*;
(
    input  logic               clk,
    input  logic               resetn,

    // requester side
    input  logic               req_valid,
    input  cpu_req_t           req,
    output logic               req_ready,

    // response completed this cycle
    input  logic               lookup_done,

    // way read port
    output logic               rd_en,
    output logic [INDEX_W-1:0] rd_index,

    // request under lookup
    output logic               lookup_valid,
    output cpu_req_t           lookup_req
);

    logic accept;

    // free when idle, or when the current response leaves this cycle
    assign req_ready = !lookup_valid || lookup_done;
    assign accept    = req_valid && req_ready;

    // ways read at the incoming index on the accept edge
    assign rd_en    = accept;
    assign rd_index = req.addr.index;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lookup_valid <= 1'b0;
        end else if (accept) begin
            lookup_valid <= 1'b1;
        end else if (lookup_done) begin
            lookup_valid <= 1'b0;
        end
    end

    // request payload, held for the whole lookup
    always_ff @(posedge clk) begin
        if (accept) begin
            lookup_req <= req;
        end
    end

endmodule

//--- src/icache_top.sv
`timescale 1ns/10ps

module icache_top
    import icache_cfg_pkg::*, icache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,

    // requester side
    input  logic         req_valid,
    output logic         req_ready,
    input  cpu_req_t     req,
    output logic         resp_valid,
    input  logic         resp_ready,
    output cpu_resp_t    resp,

    // memory side
    output logic         mem_req_valid,
    input  logic         mem_req_ready,
    output mem_rd_req_t  mem_req,
    input  logic         mem_resp_valid,
    input  mem_rd_resp_t mem_resp
);

    logic                rd_en;
    logic [INDEX_W-1:0]  rd_index;
    logic                lookup_valid;
    cpu_req_t            lookup_req;
    logic                lookup_miss;
    logic                lookup_done;
    way_out_t            way_out [NUM_WAYS];
    logic                fill_valid;
    word_t               fill_word;
    logic [NUM_WAYS-1:0] wr_en;
    logic [INDEX_W-1:0]  wr_index;
    logic [TAG_W-1:0]    wr_tag;
    line_t               wr_line;

    icache_req_stage req_stage_i (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .lookup_done  (lookup_done),
        .rd_en        (rd_en),
        .rd_index     (rd_index),
        .lookup_valid (lookup_valid),
        .lookup_req   (lookup_req)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : gen_way
        icache_way way_i (
            .clk      (clk),
            .resetn   (resetn),
            .rd_en    (rd_en),
            .rd_index (rd_index),
            .rd_out   (way_out[g]),
            .wr_en    (wr_en[g]),
            .wr_index (wr_index),
            .wr_tag   (wr_tag),
            .wr_line  (wr_line)
        );
    end

    icache_hit_select hit_select_i (
        .way_out      (way_out),
        .lookup_valid (lookup_valid),
        .lookup_req   (lookup_req),
        .fill_valid   (fill_valid),
        .fill_word    (fill_word),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp),
        .lookup_miss  (lookup_miss),
        .lookup_done  (lookup_done)
    );

    icache_refill_ctrl refill_ctrl_i (
        .clk            (clk),
        .resetn         (resetn),
        .lookup_req     (lookup_req),
        .lookup_miss    (lookup_miss),
        .lookup_done    (lookup_done),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp       (mem_resp),
        .fill_valid     (fill_valid),
        .fill_word      (fill_word),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_tag         (wr_tag),
        .wr_line        (wr_line)
    );

endmodule

//--- src/icache_way.sv
`timescale 1ns/10ps

module icache_way
    import icache_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               resetn,

    // registered read port
    input  logic               rd_en,
    input  logic [INDEX_W-1:0] rd_index,
    output way_out_t           rd_out,

    // refill write port
    input  logic               wr_en,
    input  logic [INDEX_W-1:0] wr_index,
    input  logic [TAG_W-1:0]   wr_tag,
    input  line_t              wr_line
);

    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;

    // reset empties the whole way
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (wr_en) begin
            valid_bits[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
    end

    // output holds between reads so a stalled lookup keeps its data
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_out.valid <= valid_bits[rd_index];
            rd_out.tag   <= tag_mem[rd_index];
            rd_out.line  <= line_mem[rd_index];
        end
    end

endmodule

//--- tb/icache_props.sv
`timescale 1ns/10ps

module icache_props
    import icache_cfg_pkg::*, icache_bus_pkg::*;
(
    input logic        clk,
    input logic        resetn,
    input logic        resp_valid,
    input logic        resp_ready,
    input cpu_resp_t   resp,
    input logic        mem_req_valid,
    input logic        mem_req_ready,
    input mem_rd_req_t mem_req
);

    // stalled response keeps its word
    resp_held: assert property (@(posedge clk) disable iff (!resetn)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response changed while resp_ready was low");

    mem_req_held: assert property (@(posedge clk) disable iff (!resetn)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request changed before mem_req_ready");

    // refill FSM leaves reset idle
    mem_req_quiet: assert property (@(posedge clk) $rose(resetn) |-> !mem_req_valid)
        else $error("mem_req_valid high right after reset");

endmodule

bind icache_top icache_props props_i (.*);

//--- tb/icache_tb.sv
`timescale 1ns/10ps

module icache_tb
    import icache_cfg_pkg::*, icache_bus_pkg::*;
();

    localparam time         CLK_PERIOD = 8;
    localparam int          WAIT_LIMIT = 2000;
    localparam word_t       MODEL_KEY  = 32'h5a5a_0000;
    localparam logic [31:0] SEED       = 32'hde47_f209;

    logic         clk            = 1'b0;
    logic         resetn         = 1'b0;
    logic         req_valid      = 1'b0;
    cpu_req_t     req            = '0;
    logic         req_ready;
    logic         resp_valid;
    logic         resp_ready     = 1'b1;
    cpu_resp_t    resp;
    logic         mem_req_valid;
    logic         mem_req_ready  = 1'b1;
    mem_rd_req_t  mem_req;
    logic         mem_resp_valid = 1'b0;
    mem_rd_resp_t mem_resp       = '0;

    word_t        exp_q [$];
    mem_rd_req_t  mem_log [$];
    int           line_cnt    = 0;
    int           word_cnt    = 0;
    int           served      = 0;
    int           beats_left  = 0;
    logic [31:0]  beat_addr   = '0;
    int           err_cnt     = 0;
    int           check_cnt   = 0;
    int           resp_errs   = 0;
    int           resp_checks = 0;
    int           tests_run   = 0;
    int           pred_misses = 0;
    time          accept_time = 0;
    time          resp_time   = 0;
    logic         stall_en    = 1'b0;
    logic [31:0]  stall_lfsr  = SEED;
    logic [31:0]  stim_lfsr   = SEED;

    // reference copy of tags and replacement state
    logic [TAG_W-1:0]    model_tag   [NUM_WAYS][NUM_SETS];
    logic                model_valid [NUM_WAYS][NUM_SETS];
    logic [WAY_ID_W-1:0] model_rr;

    icache_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic int count_errors();
        return err_cnt + resp_errs;
    endfunction

    // random stalls on both ready inputs
    always @(negedge clk) begin
        if (stall_en) begin
            stall_lfsr = lfsr_step(stall_lfsr);
            resp_ready = stall_lfsr[0];
            stall_lfsr = lfsr_step(stall_lfsr);
            mem_req_ready = stall_lfsr[0];
        end else begin
            resp_ready = 1'b1;
            mem_req_ready = 1'b1;
        end
    end

    // memory model logs each accepted read
    always @(posedge clk) begin
        if (resetn && mem_req_valid && mem_req_ready) begin
            mem_log.push_back(mem_req);
            if (mem_req.rd_type == RD_TYPE_LINE) begin
                line_cnt++;
            end else begin
                word_cnt++;
            end
        end
    end

    // one beat per cycle with each word set to its byte address xor the key
    always @(negedge clk) begin
        mem_resp_valid = 1'b0;
        if (beats_left == 0 && served < mem_log.size()) begin
            beat_addr = mem_log[served].addr;
            beats_left = (mem_log[served].rd_type == RD_TYPE_LINE) ? WORDS_PER_LINE : 1;
            served++;
        end
        if (beats_left != 0) begin
            mem_resp_valid = 1'b1;
            mem_resp.data = beat_addr ^ MODEL_KEY;
            mem_resp.last = (beats_left == 1);
            beat_addr = beat_addr + 32'd4;
            beats_left--;
        end
    end

    task automatic compare_resp(input cpu_resp_t got, input cpu_resp_t exp, input string what);
        resp_checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t: %s returned %h, expected %h", $time, what, got.data, exp.data);
            resp_errs++;
        end
    endtask

    always @(posedge clk) begin
        if (resetn && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                $display("a response arrived with no request outstanding at %0t", $time);
                resp_errs++;
            end else begin
                compare_resp(resp, cpu_resp_t'(exp_q.pop_front()), "response");
            end
            resp_time = $time;
        end
    end

    task automatic compare_mem_req(input mem_rd_req_t got, input mem_rd_req_t exp,
                                   input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("[FAIL] %0t: %s was type %b addr %h, expected type %b addr %h", $time,
                     what, got.rd_type, got.addr, exp.rd_type, exp.addr);
            err_cnt++;
        end
    endtask

    task automatic expect_count(input int got, input int exp, input string what);
        check_cnt++;
        if (got != exp) begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_level(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_one_req(input int log_base, input mem_rd_req_t exp, input string what);
        expect_count(mem_log.size() - log_base, 1, {what, " count"});
        if (mem_log.size() > log_base) begin
            compare_mem_req(mem_log[log_base], exp, what);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout at %0t: %s", $time, why);
        $display("Errors found");
        $finish;
    endtask

    task automatic finish_test(input string name, input int err_base);
        tests_run++;
        $display("test %s finished with %0d errors", name, count_errors() - err_base);
    endtask

    function automatic void model_access(input logic [31:0] addr);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[w][addr[11:4]] && model_tag[w][addr[11:4]] == addr[31:12]) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            model_valid[model_rr][addr[11:4]] = 1'b1;
            model_tag[model_rr][addr[11:4]] = addr[31:12];
            model_rr = ~model_rr;
            pred_misses++;
        end
    endfunction

    task automatic apply_reset();
        resetn = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                model_valid[w][s] = 1'b0;
            end
        end
        model_rr = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    endtask

    // leaves req_valid high so the next call can follow back to back
    task automatic send_req(input logic [31:0] addr, input logic unc);
        int   waited;
        logic accepted;
        @(negedge clk);
        req_valid = 1'b1;
        req.addr = addr;
        req.uncached = unc;
        accepted = 1'b0;
        waited = 0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = req_ready;
            waited++;
        end
        if (!accepted) begin
            abort_run("the cache never accepted a request");
        end else begin
            accept_time = $time;
            if (unc) begin
                exp_q.push_back(addr ^ MODEL_KEY);
            end else begin
                exp_q.push_back({addr[31:2], 2'b00} ^ MODEL_KEY);
                model_access(addr);
            end
        end
    endtask

    task automatic wait_idle();
        int waited;
        @(negedge clk);
        req_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            abort_run("responses were still missing");
        end
    endtask

    task automatic read_counted(input logic [31:0] addr, input int exp_lines, input string what);
        int line_base;
        line_base = line_cnt;
        send_req(addr, 1'b0);
        wait_idle();
        expect_count(line_cnt - line_base, exp_lines, what);
    endtask

    task automatic after_reset();
        int err_base;
        err_base = count_errors();
        expect_level(req_ready, 1'b1, "req_ready");
        expect_level(resp_valid, 1'b0, "resp_valid");
        expect_level(mem_req_valid, 1'b0, "mem_req_valid");
        finish_test("after_reset", err_base);
    endtask

    task automatic hit_after_fill();
        int          err_base;
        int          log_base;
        mem_rd_req_t exp_req;
        err_base = count_errors();
        log_base = mem_log.size();
        send_req(32'h0001_234c, 1'b0);
        wait_idle();
        exp_req.rd_type = RD_TYPE_LINE;
        exp_req.addr = 32'h0001_2340;
        expect_one_req(log_base, exp_req, "cold line read");
        log_base = mem_log.size();
        send_req(32'h0001_2344, 1'b0);
        wait_idle();
        expect_count(mem_log.size() - log_base, 0, "memory reads on a hit");
        expect_count(int'((resp_time - accept_time) / CLK_PERIOD), 1, "hit latency");
        finish_test("hit_after_fill", err_base);
    endtask

    task automatic round_robin_replace();
        int err_base;
        err_base = count_errors();
        read_counted(32'h0000_a404, 1, "fill of A");
        read_counted(32'h0000_b408, 1, "fill of B");
        // A touched last, so only the fill order picks the victim
        read_counted(32'h0000_b408, 0, "hit on B");
        read_counted(32'h0000_a404, 0, "hit on A");
        read_counted(32'h0000_c40c, 1, "C evicting A");
        read_counted(32'h0000_a404, 1, "A evicting B");
        read_counted(32'h0000_c40c, 0, "hit on C");
        read_counted(32'h0000_b408, 1, "refill of evicted B");
        finish_test("round_robin_replace", err_base);
    endtask

    task automatic uncached_read();
        int          err_base;
        int          log_base;
        int          word_base;
        mem_rd_req_t exp_req;
        err_base = count_errors();
        log_base = mem_log.size();
        word_base = word_cnt;
        send_req(32'h0002_3458, 1'b1);
        wait_idle();
        exp_req.rd_type = RD_TYPE_WORD;
        exp_req.addr = 32'h0002_3458;
        expect_one_req(log_base, exp_req, "uncached word read");
        expect_count(word_cnt - word_base, 1, "word reads");
        read_counted(32'h0002_3450, 1, "cached read after uncached");
        finish_test("uncached_read", err_base);
    endtask

    task automatic random_stalls();
        logic [31:0] addrs [40];
        logic [31:0] tag_bits;
        logic [31:0] idx_bits;
        logic [31:0] word_bits;
        int          err_base;
        int          line_base;
        int          miss_base;
        err_base = count_errors();
        // four tags over four sets so lines get reused and evicted
        for (int i = 0; i < 40; i++) begin
            tag_bits = take_bits(2);
            idx_bits = take_bits(2);
            word_bits = take_bits(2);
            addrs[i] = {18'h00200, tag_bits[1:0], 6'h18, idx_bits[1:0], word_bits[1:0], 2'b00};
        end
        line_base = line_cnt;
        miss_base = pred_misses;
        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_req(addrs[i], 1'b0);
        end
        wait_idle();
        stall_en = 1'b0;
        expect_count(line_cnt - line_base, pred_misses - miss_base, "line reads under stalls");
        finish_test("random_stalls", err_base);
    endtask

    initial begin
        apply_reset();
        after_reset();
        hit_after_fill();
        round_robin_replace();
        uncached_read();
        random_stalls();
        $display("%0d tests, %0d checks, %0d errors", tests_run, check_cnt + resp_checks,
                 count_errors());
        if (count_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
